/* common/mmio_defs.svh */
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// Bus widths seen by the core side of the block.
`define MMIO_ADDR_W 32 // Byte address.
`define MMIO_DATA_W 64 // One double word per access.

// Peripheral widths.
`define MMIO_KB_W  8  // Keyboard scan code.
`define MMIO_SEG_W 32 // Value shown on the seven-segment display.

// Data RAM window, 4096 bytes or 512 double words.
`define MMIO_RAM_BASE 32'h8000_0000
`define MMIO_RAM_LEN  4096

// Each peripheral decodes an 8 byte window.
`define MMIO_KB_BASE  32'ha000_0000 // Keyboard port, read only.
`define MMIO_SEG_BASE 32'ha000_0100 // Display register, write only.
`define MMIO_PERI_LEN 8

// Returned by any read that finds nothing to return.
// The core treats it as "no data", so keep it recognizable.
`define MMIO_IDLE_DATA 64'h0000_0000_ffff_aaaa

`endif

/* common/mmio_pkg.sv */
package mmio_pkg;

    // Region hit by an address, as classified by the decoder.
    typedef enum logic [1:0] {
        REGION_NONE, // Outside every window.
        REGION_RAM,  // Data RAM.
        REGION_KB,   // Keyboard port.
        REGION_SEG   // Display register.
    } mmio_region_e;

    // Width operation of a load or store.
    // The plain forms sign-extend loads and the U forms zero-extend them.
    // Stores only look at the size, so WOP_B and WOP_BU write the same byte.
    typedef enum logic [2:0] {
        WOP_B,  // Byte.
        WOP_H,  // Half word, 2 bytes.
        WOP_W,  // Word, 4 bytes.
        WOP_D,  // Double word, 8 bytes.
        WOP_BU, // Byte, unsigned.
        WOP_HU, // Half word, unsigned.
        WOP_WU  // Word, unsigned.
    } mmio_wop_e;

endpackage

/* mmio/mmio_decode.sv */
`include "mmio_defs.svh"

module mmio_decode (
    input  logic [`MMIO_ADDR_W-1:0] raddr,   // Load address.
    input  logic [`MMIO_ADDR_W-1:0] waddr,   // Store address.
    output mmio_pkg::mmio_region_e  rregion, // Region of the load.
    output mmio_pkg::mmio_region_e  wregion  // Region of the store.
);

    import mmio_pkg::*;

    // True when addr falls in [base, base + len).
    // Subtracting first keeps the compare safe near the top of the map.
    function automatic logic in_window(
        input logic [`MMIO_ADDR_W-1:0] addr,
        input logic [`MMIO_ADDR_W-1:0] base,
        input int unsigned             len
    );
        logic [`MMIO_ADDR_W-1:0] offset;
        offset = addr - base;
        return (addr >= base) && (offset < len);
    endfunction

    // Map one address onto its region. The windows do not overlap,
    // so the order of the tests only matters for readability.
    function automatic mmio_region_e classify(input logic [`MMIO_ADDR_W-1:0] addr);
        mmio_region_e region;
        region = REGION_NONE;
        if (in_window(addr, `MMIO_RAM_BASE, `MMIO_RAM_LEN)) begin
            region = REGION_RAM;
        end else if (in_window(addr, `MMIO_KB_BASE, `MMIO_PERI_LEN)) begin
            region = REGION_KB;
        end else if (in_window(addr, `MMIO_SEG_BASE, `MMIO_PERI_LEN)) begin
            region = REGION_SEG;
        end
        return region;
    endfunction

    // Both ports are decoded independently, since a load and a store
    // can be in flight in the same cycle.
    always_comb begin
        rregion = classify(raddr); // Level, follows raddr only.
        wregion = classify(waddr); // Level, follows waddr only.
    end

endmodule

/* mmio/mmio_ram.sv */
`include "mmio_defs.svh"

module mmio_ram (
    input  logic                    clk,
    input  logic [`MMIO_ADDR_W-1:0] waddr,   // Store byte address.
    input  logic [`MMIO_DATA_W-1:0] wdata,   // Store data, right aligned.
    input  logic                    wen,     // Store strobe from the core.
    input  mmio_pkg::mmio_region_e  wregion, // Region of waddr.
    input  logic [`MMIO_ADDR_W-1:0] raddr,   // Load byte address.
    input  mmio_pkg::mmio_wop_e     wop,     // Access width and signedness.
    output logic [`MMIO_DATA_W-1:0] rdata    // Load data, already extended.
);

    import mmio_pkg::*;

    localparam int unsigned BYTES   = `MMIO_DATA_W / 8;
    localparam int unsigned DEPTH   = `MMIO_RAM_LEN / BYTES; // 512 double words.
    localparam int unsigned IDX_W   = $clog2(DEPTH);
    localparam int unsigned LANE_W  = $clog2(BYTES);         // Byte offset bits.

    logic [`MMIO_DATA_W-1:0] mem [DEPTH];

    logic [IDX_W-1:0]        widx;
    logic [IDX_W-1:0]        ridx;
    logic                    ram_we;
    logic [BYTES-1:0]        wmask;
    logic [`MMIO_DATA_W-1:0] wshift;
    logic [`MMIO_DATA_W-1:0] rword;
    logic [`MMIO_DATA_W-1:0] rlane;

    // Byte mask of an access at lane 0. Signed and unsigned forms match.
    function automatic logic [BYTES-1:0] size_mask(input mmio_wop_e op);
        logic [BYTES-1:0] mask;
        case (op)
            WOP_B, WOP_BU: mask = 8'h01;
            WOP_H, WOP_HU: mask = 8'h03;
            WOP_W, WOP_WU: mask = 8'h0f;
            default:       mask = 8'hff; // Double word.
        endcase
        return mask;
    endfunction

    // The window is aligned to its own size, so the base drops out of the index.
    assign widx = waddr[IDX_W+LANE_W-1:LANE_W];
    assign ridx = raddr[IDX_W+LANE_W-1:LANE_W];

    assign ram_we = wen && (wregion == REGION_RAM); // Stores elsewhere never touch the RAM.

    // Move the store into its lanes; accesses are naturally aligned.
    assign wmask  = size_mask(wop) << waddr[LANE_W-1:0];
    assign wshift = wdata << {waddr[LANE_W-1:0], 3'b000};

    // Only the enabled bytes are written, the rest of the double word is kept.
    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int i = 0; i < BYTES; i++) begin
                if (wmask[i]) begin
                    mem[widx][i*8 +: 8] <= wshift[i*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read. A same-cycle store is seen one cycle later.
    assign rword = mem[ridx];
    assign rlane = rword >> {raddr[LANE_W-1:0], 3'b000}; // Addressed lane to bit 0.

    always_comb begin
        case (wop)
            WOP_B:   rdata = {{56{rlane[7]}},  rlane[7:0]};
            WOP_H:   rdata = {{48{rlane[15]}}, rlane[15:0]};
            WOP_W:   rdata = {{32{rlane[31]}}, rlane[31:0]};
            WOP_BU:  rdata = {56'd0, rlane[7:0]};
            WOP_HU:  rdata = {48'd0, rlane[15:0]};
            WOP_WU:  rdata = {32'd0, rlane[31:0]};
            default: rdata = rlane; // Full double word, nothing to extend.
        endcase
    end

endmodule

/* mmio/mmio_seg_reg.sv */
`include "mmio_defs.svh"

module mmio_seg_reg (
    input  logic                    clk,
    input  logic                    arst_n,    // Asynchronous clear, active low.
    input  logic                    wen,       // Store strobe from the core.
    input  mmio_pkg::mmio_region_e  wregion,   // Region of the store address.
    input  logic [`MMIO_DATA_W-1:0] wdata,     // Store data.
    output logic [`MMIO_SEG_W-1:0]  seg_value  // Value for the display driver.
);

    import mmio_pkg::*;

    logic seg_we;

    // Any width of store to the window loads the register.
    assign seg_we = wen && (wregion == REGION_SEG);

    // The display shows blanks (zero) until the first store after reset.
    // Loading on the rising edge keeps the block on a single clock edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_value <= '0;
        end else if (seg_we) begin
            seg_value <= wdata[`MMIO_SEG_W-1:0]; // Low 32 bits only.
        end
    end

endmodule

/* mmio/mmio_read_mux.sv */
`include "mmio_defs.svh"

module mmio_read_mux (
    input  logic                    ren,       // Load strobe from the core.
    input  mmio_pkg::mmio_region_e  rregion,   // Region of the load address.
    input  logic [`MMIO_DATA_W-1:0] ram_rdata, // Extended RAM data.
    input  logic [`MMIO_KB_W-1:0]   kb_data,   // Waiting keyboard code.
    input  logic                    kb_ready,  // A code is waiting.
    output logic [`MMIO_DATA_W-1:0] rdata,     // Load result to the core.
    output logic                    kb_ack     // Tells the keyboard the code was taken.
);

    import mmio_pkg::*;

    // Purely combinational, the core samples rdata in the same cycle.
    always_comb begin
        rdata  = `MMIO_IDLE_DATA; // Default for misses and idle cycles.
        kb_ack = 1'b0;
        if (ren) begin
            case (rregion)
                REGION_RAM: begin
                    rdata = ram_rdata;
                end
                REGION_KB: begin
                    // With no code waiting the read is treated like a miss.
                    if (kb_ready) begin
                        rdata  = {{(`MMIO_DATA_W-`MMIO_KB_W){1'b0}}, kb_data};
                        kb_ack = 1'b1; // The source drops the code on the next edge.
                    end
                end
                default: begin
                    // The display register is write only, it reads as idle.
                    rdata = `MMIO_IDLE_DATA;
                end
            endcase
        end
    end

endmodule

/* mmio/mmio.sv */
`include "mmio_defs.svh"

module mmio (
    input  logic                    clk,
    input  logic                    arst_n,    // Asynchronous reset, active low.
    input  logic [`MMIO_ADDR_W-1:0] raddr,     // Load byte address.
    input  logic                    ren,       // Load strobe.
    input  logic [`MMIO_ADDR_W-1:0] waddr,     // Store byte address.
    input  logic [`MMIO_DATA_W-1:0] wdata,     // Store data.
    input  logic                    wen,       // Store strobe.
    input  mmio_pkg::mmio_wop_e     wop,       // Width of the active access.
    input  logic [`MMIO_KB_W-1:0]   kb_data,   // Keyboard code.
    input  logic                    kb_ready,  // Keyboard code is waiting.
    output logic [`MMIO_DATA_W-1:0] rdata,     // Load result.
    output logic                    kb_ack,    // Keyboard code consumed.
    output logic [`MMIO_SEG_W-1:0]  seg_value  // Display register.
);

    import mmio_pkg::*;

    mmio_region_e            rregion;
    mmio_region_e            wregion;
    logic [`MMIO_DATA_W-1:0] ram_rdata;

    // Decode both addresses once; every other block works off the region.
    mmio_decode u_decode (
        .raddr   (raddr),
        .waddr   (waddr),
        .rregion (rregion),
        .wregion (wregion)
    );

    // The RAM qualifies its own write enable with wregion.
    mmio_ram u_ram (
        .clk     (clk),
        .waddr   (waddr),
        .wdata   (wdata),
        .wen     (wen),
        .wregion (wregion),
        .raddr   (raddr),
        .wop     (wop),
        .rdata   (ram_rdata)
    );

    mmio_seg_reg u_seg_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .wen       (wen),
        .wregion   (wregion),
        .wdata     (wdata),
        .seg_value (seg_value)
    );

    // Final load result, RAM data or keyboard code or the idle pattern.
    mmio_read_mux u_read_mux (
        .ren       (ren),
        .rregion   (rregion),
        .ram_rdata (ram_rdata),
        .kb_data   (kb_data),
        .kb_ready  (kb_ready),
        .rdata     (rdata),
        .kb_ack    (kb_ack)
    );

endmodule

/* verification/mmio_checker.sv */
`include "mmio_defs.svh"

module mmio_checker (
    input logic                    clk,
    input logic                    arst_n,
    input logic [`MMIO_ADDR_W-1:0] raddr,
    input logic                    ren,
    input logic [`MMIO_ADDR_W-1:0] waddr,
    input logic [`MMIO_DATA_W-1:0] wdata,
    input logic                    wen,
    input logic                    kb_ready,
    input logic [`MMIO_DATA_W-1:0] rdata,
    input logic                    kb_ack,
    input logic [`MMIO_SEG_W-1:0]  seg_value
);

    int unsigned fails = 0; // Failed assertions so far, read by the testbench.

    logic kb_hit;   // Load address inside the keyboard window.
    logic seg_whit; // Store address inside the display window.

    // Own window compares, kept apart from the decoder in the design.
    assign kb_hit   = (raddr >= `MMIO_KB_BASE) && (raddr < (`MMIO_KB_BASE + `MMIO_PERI_LEN));
    assign seg_whit = (waddr >= `MMIO_SEG_BASE) && (waddr < (`MMIO_SEG_BASE + `MMIO_PERI_LEN));

    // The acknowledge only comes from a keyboard read that finds a code.
    ack_source: assert property (@(posedge clk) disable iff (!arst_n)
        kb_ack |-> (ren && kb_hit && kb_ready))
        else begin
            fails++;
            $error("kb_ack high without a keyboard read of a waiting code");
        end

    // The display register only moves one edge after a store to its window.
    seg_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(seg_value) |-> $past(wen && seg_whit))
        else begin
            fails++;
            $error("seg_value changed without a store to the display window");
        end

    // And when it is stored to, it takes the low half of the store data.
    seg_load: assert property (@(posedge clk) disable iff (!arst_n)
        (wen && seg_whit) |=> (seg_value == $past(wdata[`MMIO_SEG_W-1:0])))
        else begin
            fails++;
            $error("seg_value did not load the low bits of the store");
        end

    kb_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (ren && kb_hit && kb_ready) |-> (rdata[`MMIO_DATA_W-1:`MMIO_KB_W] == '0))
        else begin
            fails++;
            $error("keyboard read data not zero above the code");
        end

    // No load in progress means the bus shows the idle pattern.
    idle_data: assert property (@(posedge clk) disable iff (!arst_n)
        !ren |-> (rdata == `MMIO_IDLE_DATA))
        else begin
            fails++;
            $error("rdata is not the idle pattern while ren is low");
        end

endmodule

bind mmio mmio_checker chk0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .raddr     (raddr),
    .ren       (ren),
    .waddr     (waddr),
    .wdata     (wdata),
    .wen       (wen),
    .kb_ready  (kb_ready),
    .rdata     (rdata),
    .kb_ack    (kb_ack),
    .seg_value (seg_value)
);

/* verification/mmio_tb.sv */
`include "mmio_defs.svh"

module mmio_tb;

    import mmio_pkg::*;

    localparam int N_LOC  = 16; // Double words used by the RAM tests.
    localparam int N_OVER = 24; // Sized overwrites.
    localparam int N_KB   = 8;
    localparam int N_SEG  = 6;
    localparam int N_RW   = 6;

    // Cycle budget of each test, used by the watchdog.
    localparam int RAM_CYCLES  = N_LOC + N_OVER + N_LOC * 29 + 2; // 29 reads per location.
    localparam int KB_CYCLES   = N_KB * 4 + 1;
    localparam int SEG_CYCLES  = N_SEG * 7 + 1;
    localparam int IDLE_CYCLES = 14;
    localparam int RW_CYCLES   = N_RW * 4;
    localparam int ALL_CYCLES  = 3 + RAM_CYCLES + KB_CYCLES + SEG_CYCLES + IDLE_CYCLES + RW_CYCLES;

    logic                    clk;
    logic                    arst_n;
    logic [`MMIO_ADDR_W-1:0] raddr;
    logic                    ren;
    logic [`MMIO_ADDR_W-1:0] waddr;
    logic [`MMIO_DATA_W-1:0] wdata;
    logic                    wen;
    mmio_wop_e               wop;
    logic [`MMIO_KB_W-1:0]   kb_data;
    logic                    kb_ready;
    logic [`MMIO_DATA_W-1:0] rdata;
    logic                    kb_ack;
    logic [`MMIO_SEG_W-1:0]  seg_value;

    logic [7:0]  ram_model [`MMIO_RAM_LEN]; // Byte image of the data RAM.
    logic [31:0] seg_model;                 // Expected display value.
    logic [31:0] locs [N_LOC];              // Addresses of the tested double words.
    int          seed;
    int          checks;
    int          errors;
    int          chk_mark;
    int          err_mark;
    int          asrt_mark;
    string       test_name;

    mmio dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .raddr     (raddr),
        .ren       (ren),
        .waddr     (waddr),
        .wdata     (wdata),
        .wen       (wen),
        .wop       (wop),
        .kb_data   (kb_data),
        .kb_ready  (kb_ready),
        .rdata     (rdata),
        .kb_ack    (kb_ack),
        .seg_value (seg_value)
    );

    always #5 clk = ~clk; // Period of 10.

    function automatic int op_bytes(input mmio_wop_e op);
        case (op)
            WOP_B, WOP_BU: return 1;
            WOP_H, WOP_HU: return 2;
            WOP_W, WOP_WU: return 4;
            default:       return 8;
        endcase
    endfunction

    // Only the U forms zero-extend.
    function automatic logic op_signed(input mmio_wop_e op);
        return (op == WOP_B) || (op == WOP_H) || (op == WOP_W) || (op == WOP_D);
    endfunction

    function automatic logic in_ram(input logic [31:0] addr);
        return (addr >= `MMIO_RAM_BASE) && (addr < (`MMIO_RAM_BASE + `MMIO_RAM_LEN));
    endfunction

    // Apply a store to the models. Bytes go in little-endian order.
    function automatic void model_write(input logic [31:0] addr, input logic [63:0] data,
                                        input mmio_wop_e op);
        int off;
        off = addr - `MMIO_RAM_BASE;
        if (in_ram(addr)) begin
            for (int i = 0; i < op_bytes(op); i++) begin
                ram_model[off + i] = data[i*8 +: 8];
            end
        end
        if ((addr >= `MMIO_SEG_BASE) && (addr < (`MMIO_SEG_BASE + `MMIO_PERI_LEN))) begin
            seg_model = data[31:0];
        end
    endfunction

    // Expected load result, built byte by byte and then extended.
    function automatic logic [63:0] expect_load(input logic [31:0] addr, input mmio_wop_e op);
        int          n;
        int          off;
        logic [63:0] v;
        n   = op_bytes(op);
        off = addr - `MMIO_RAM_BASE;
        v   = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < n) begin
                v[i*8 +: 8] = ram_model[off + i];
            end else if (op_signed(op) && v[n*8-1]) begin
                v[i*8 +: 8] = 8'hff; // Copy the sign bit up.
            end
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        chk_mark  = checks;
        err_mark  = errors;
        asrt_mark = dut0.chk0.fails;
    endtask

    task automatic end_test;
        $display("%-10s done: %0d checks, %0d mismatches, %0d assertion failures", test_name,
                 checks - chk_mark, errors - err_mark, dut0.chk0.fails - asrt_mark);
    endtask

    // One store cycle. The models are updated as the store is issued.
    task automatic store(input logic [31:0] addr, input logic [63:0] data, input mmio_wop_e op);
        @(posedge clk);
        waddr <= addr;
        wdata <= data;
        wop   <= op;
        wen   <= 1'b1;
        ren   <= 1'b0;
        model_write(addr, data, op);
    endtask

    // One load cycle, checked in the middle of the cycle where rdata has settled.
    task automatic read_check(input logic [31:0] addr, input logic rd, input mmio_wop_e op,
                              input logic [63:0] exp, input logic ack_exp);
        @(posedge clk);
        raddr <= addr;
        ren   <= rd;
        wop   <= op;
        wen   <= 1'b0;
        @(negedge clk);
        check_value("rdata", exp, rdata);
        check_value("kb_ack", {63'd0, ack_exp}, {63'd0, kb_ack});
    endtask

    task automatic idle_cycle;
        @(posedge clk);
        wen <= 1'b0;
        ren <= 1'b0;
    endtask

    task automatic ram_sized_test;
        logic [31:0] r;
        int          k;
        int          off;
        mmio_wop_e   op;
        begin_test("ram_sized");
        for (int i = 0; i < N_LOC; i++) begin
            locs[i] = `MMIO_RAM_BASE + (i * 32 + ($random(seed) & 31)) * 8; // One per 256 bytes.
            store(locs[i], {$random(seed), $random(seed)}, WOP_D);
        end
        for (int j = 0; j < N_OVER; j++) begin
            r = $random(seed);
            k = r[3:0];
            case (r[5:4])
                2'd0:    op = WOP_B;
                2'd1:    op = WOP_HU;
                2'd2:    op = WOP_W;
                default: op = WOP_BU;
            endcase
            off = int'(r[8:6]) & ~(op_bytes(op) - 1); // Natural alignment.
            store(locs[k] + off, {$random(seed), $random(seed)}, op);
        end
        for (int i = 0; i < N_LOC; i++) begin
            for (int w = 0; w < 7; w++) begin
                op = mmio_wop_e'(w);
                for (int o = 0; o < 8; o += op_bytes(op)) begin
                    read_check(locs[i] + o, 1'b1, op, expect_load(locs[i] + o, op), 1'b0);
                end
            end
        end
        idle_cycle();
        end_test();
    endtask

    task automatic kb_test;
        logic [31:0] r;
        begin_test("kb_read");
        for (int j = 0; j < N_KB; j++) begin
            r = $random(seed);
            @(posedge clk);
            kb_data  <= r[7:0];
            kb_ready <= 1'b1;
            read_check(`MMIO_KB_BASE + r[10:8], 1'b1, WOP_BU, {56'd0, r[7:0]}, 1'b1);
            @(posedge clk);
            kb_ready <= 1'b0; // The source saw the acknowledge and drops the code.
            @(negedge clk);
            check_value("rdata no code", `MMIO_IDLE_DATA, rdata);
            check_value("kb_ack no code", 64'd0, {63'd0, kb_ack});
        end
        idle_cycle();
        end_test();
    endtask

    task automatic seg_test;
        begin_test("seg_reg");
        @(negedge clk);
        check_value("seg_value after reset", 64'd0, {32'd0, seg_value});
        for (int j = 0; j < N_SEG; j++) begin
            store(`MMIO_SEG_BASE, {$random(seed), $random(seed)}, (j % 2) ? WOP_W : WOP_D);
            idle_cycle();
            @(negedge clk);
            check_value("seg_value load", {32'd0, seg_model}, {32'd0, seg_value});
            store(`MMIO_RAM_BASE + j * 8, {$random(seed), $random(seed)}, WOP_D); // RAM store.
            store(32'h4000_0000 + j * 8, {$random(seed), $random(seed)}, WOP_W); // Unmapped.
            idle_cycle();
            @(negedge clk);
            check_value("seg_value hold", {32'd0, seg_model}, {32'd0, seg_value});
        end
        end_test();
    endtask

    task automatic idle_test;
        logic [31:0] misses [8];
        begin_test("idle_reads");
        misses = '{32'h0000_0000, 32'h7fff_fff8, `MMIO_RAM_BASE + `MMIO_RAM_LEN,
                   `MMIO_KB_BASE - 8, `MMIO_KB_BASE + 8, `MMIO_SEG_BASE,
                   `MMIO_SEG_BASE + 4, 32'hffff_fff8};
        foreach (misses[i]) begin
            read_check(misses[i], 1'b1, WOP_D, `MMIO_IDLE_DATA, 1'b0);
        end
        @(posedge clk);
        kb_ready <= 1'b1; // A waiting code must not be taken without ren.
        read_check(`MMIO_KB_BASE, 1'b0, WOP_D, `MMIO_IDLE_DATA, 1'b0);
        read_check(locs[0], 1'b0, WOP_D, `MMIO_IDLE_DATA, 1'b0);
        read_check(locs[1] + 3, 1'b0, WOP_B, `MMIO_IDLE_DATA, 1'b0);
        @(posedge clk);
        kb_ready <= 1'b0;
        end_test();
    endtask

    task automatic rw_test;
        logic [31:0] a;
        logic [63:0] nv;
        logic [63:0] old;
        begin_test("rw_same");
        for (int j = 0; j < N_RW; j++) begin
            a   = locs[($random(seed) & 32'hf)];
            nv  = {$random(seed), $random(seed)};
            old = expect_load(a, WOP_D);
            @(posedge clk);
            raddr <= a;
            ren   <= 1'b1;
            wop   <= WOP_D;
            waddr <= a;
            wdata <= nv;
            wen   <= 1'b1;
            @(negedge clk);
            check_value("rdata during write", old, rdata); // Store lands at the next edge.
            model_write(a, nv, WOP_D);
            @(posedge clk);
            wen <= 1'b0;
            @(negedge clk);
            check_value("rdata after write", expect_load(a, WOP_D), rdata);
            idle_cycle();
        end
        end_test();
    endtask

    // Watchdog, twice the summed test budget plus a margin.
    initial begin
        #((ALL_CYCLES * 2 + 50) * 10);
        $display("Watchdog expired before the tests finished.");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        raddr     = '0;
        ren       = 1'b0;
        waddr     = '0;
        wdata     = '0;
        wen       = 1'b0;
        wop       = WOP_D;
        kb_data   = '0;
        kb_ready  = 1'b0;
        seed      = 32'h153b;
        checks    = 0;
        errors    = 0;
        seg_model = '0; // Reset value of the display.
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        seg_test();      // Runs first so the reset value is still visible.
        ram_sized_test();
        kb_test();
        idle_test();
        rw_test();
        repeat (2) @(posedge clk); // Let the checker sample the last cycles.
        $display("Totals: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, dut0.chk0.fails);
        if ((errors == 0) && (dut0.chk0.fails == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/mmio_pkg.sv
mmio/mmio_decode.sv
mmio/mmio_ram.sv
mmio/mmio_seg_reg.sv
mmio/mmio_read_mux.sv
mmio/mmio.sv
verification/mmio_checker.sv
verification/mmio_tb.sv

/* Bender.yml */
package:
  name: mmio

sources:
  - include_dirs:
      - common
    files:
      - common/mmio_pkg.sv
      - mmio/mmio_decode.sv
      - mmio/mmio_ram.sv
      - mmio/mmio_seg_reg.sv
      - mmio/mmio_read_mux.sv
      - mmio/mmio.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/mmio_checker.sv
      - verification/mmio_tb.sv
